/* filelist.f */
src/perf_event_pkg.sv
src/sched_pkg.sv
src/perf_event_sampler.sv
src/stream_fifo.sv
src/mode_scheduler.sv
src/core_sched_top.sv
sim/core_sched_assert.sv
sim/core_sched_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_sched_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard src/*.sv sim/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* sim/core_sched_tb.sv */
`timescale 1ns/1ns

module core_sched_tb;
    import perf_event_pkg::*;
    import sched_pkg::*;

    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_WINDOWS   = 300;
    localparam int NUM_PHASES    = 6;
    localparam int WINDOW_BEATS  = GROUP_BEATS * WINDOW_RECORDS;
    localparam int WATCHDOG_NS   = (NUM_WINDOWS * WINDOW_BEATS * 4 + RESET_CYCLES) * CLK_PERIOD_NS;

    // flag probability in eighths per phase.
    // nibble 8 is ooo_mult and nibble 0 is ppl_alu.
    // phase 1 casts only the rob and alu votes and phase 2 only mem and flush.
    localparam logic [8:0][3:0] PHASE_LEVELS [NUM_PHASES] = '{
        36'h444444444, 36'h622712667, 36'h666162222,
        36'h177717117, 36'h711171771, 36'h453434354
    };

    logic                   clk;
    logic                   rst;
    logic                   beat_valid;
    logic                   beat_ready;
    logic [8:0]             flags;
    logic                   decision_valid;
    logic                   decision_ready;
    logic [WINDOW_ID_W-1:0] decision_window;
    logic [NUM_VOTES-1:0]   decision_votes;
    logic                   decision_switch;

    logic [31:0] lfsr_state = 32'hecdb;
    int          model_sum [9];
    int          model_beats;
    int          model_window;
    decision_t   expected_q [$];
    int          decisions_seen;
    int          value_errors;
    int          other_errors;

    core_sched_top dut_i (
        .clk, .rst,
        .beat_valid, .beat_ready,
        .ooo_mult(flags[8]), .ooo_mem(flags[7]), .ooo_flush(flags[6]),
        .ooo_rob_full(flags[5]), .ooo_alu(flags[4]),
        .ppl_mult(flags[3]), .ppl_mem(flags[2]), .ppl_flush(flags[1]), .ppl_alu(flags[0]),
        .decision_valid, .decision_ready,
        .decision_window, .decision_votes, .decision_switch
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic string format_decision(input decision_t d);
        return $sformatf("id=%0d votes=%b switch=%b", d.window_id, d.votes, d.switch_en);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        repeat (n) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_flags(input int phase);
        logic [31:0] r;
        for (int i = 8; i >= 0; i--) begin
            draw_bits(3, r);
            flags[i] = {1'b0, r[2:0]} < PHASE_LEVELS[phase][i];
        end
    endtask

    // closes a window from the beat sums with the scheduler's voting rules.
    task automatic close_window();
        decision_t exp;
        int        cast;
        exp.window_id         = WINDOW_ID_W'(model_window);
        exp.votes[VOTE_MULT]  = model_sum[8] < model_sum[3];
        exp.votes[VOTE_MEM]   = model_sum[7] > model_sum[2];
        exp.votes[VOTE_FLUSH] = model_sum[6] > model_sum[1];
        exp.votes[VOTE_ROB]   = model_sum[5] > int'(ROB_FULL_THRESHOLD);
        exp.votes[VOTE_ALU]   = model_sum[4] < model_sum[0];
        cast = 0;
        for (int v = 0; v < NUM_VOTES; v++) begin
            cast += int'(exp.votes[v]);
        end
        exp.switch_en = (cast >= 3) || (exp.votes[VOTE_ROB] && exp.votes[VOTE_ALU]);
        expected_q.push_back(exp);
        model_window++;
        model_beats = 0;
        for (int i = 0; i < 9; i++) begin
            model_sum[i] = 0;
        end
    endtask

    task automatic accept_beat();
        for (int i = 0; i < 9; i++) begin
            model_sum[i] += int'(flags[i]);
        end
        model_beats++;
        if (model_beats == WINDOW_BEATS) begin
            close_window();
        end
    endtask

    task automatic check_decision();
        decision_t exp;
        decision_t act;
        act.window_id = decision_window;
        act.votes     = decision_votes;
        act.switch_en = decision_switch;
        decisions_seen++;
        if (expected_q.size() == 0) begin
            other_errors++;
            $display("decision %0d arrived before the model closed a window", act.window_id);
        end else begin
            exp = expected_q.pop_front();
            assert (act == exp) else begin
                value_errors++;
                $display("[ERROR] decision_check: expected %s, actual %s",
                         format_decision(exp), format_decision(act));
            end
        end
    endtask

    // beats and decision_ready stalls share one lfsr sequence.
    task automatic run_traffic();
        logic [31:0] r;
        logic        need_new;
        int          beats_sent;
        int          phase;
        beats_sent = 0;
        need_new   = 1'b1;
        while (decisions_seen < NUM_WINDOWS) begin
            @(posedge clk);
            #1;
            if (need_new) begin
                beat_valid = 1'b0;
                if (beats_sent < NUM_WINDOWS * WINDOW_BEATS) begin
                    draw_bits(2, r);
                    if (r[1:0] != 2'b00) begin
                        beat_valid = 1'b1;
                        draw_flags((beats_sent / WINDOW_BEATS) % NUM_PHASES);
                        need_new = 1'b0;
                    end
                end
            end
            // phase 5 stalls the output hard to fill the pipeline.
            phase = decisions_seen % NUM_PHASES;
            draw_bits(2, r);
            decision_ready = (phase == 5) ? (r[1:0] == 2'b00) : (r[1:0] != 2'b00);
            @(negedge clk);
            if (beat_valid && beat_ready) begin
                accept_beat();
                beats_sent++;
                need_new = 1'b1;
            end
            if (decision_valid && decision_ready) begin
                check_decision();
            end
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        assert_errors = dut_i.assert_i.fail_count;
        $display("checked %0d decisions: %0d value, %0d other, %0d assertion errors",
                 decisions_seen, value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        rst            = 1'b1;
        beat_valid     = 1'b0;
        flags          = '0;
        decision_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (beat_ready && !decision_valid) else begin
            other_errors++;
            $display("after reset beat_ready is not high or decision_valid is not low");
        end
        run_traffic();
        // no decision may follow the last window.
        @(posedge clk);
        #1;
        beat_valid     = 1'b0;
        decision_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            assert (!decision_valid) else begin
                other_errors++;
                $display("extra decision %0d after the last window", decision_window);
            end
        end
        report_and_finish();
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("watchdog expired: decisions stopped arriving after %0d of %0d",
                 decisions_seen, NUM_WINDOWS);
        report_and_finish();
    end

endmodule

/* sim/core_sched_assert.sv */
`timescale 1ns/1ns

module core_sched_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              beat_ready,
    input logic                              decision_valid,
    input logic                              decision_ready,
    input logic [sched_pkg::WINDOW_ID_W-1:0] decision_window,
    input logic [sched_pkg::NUM_VOTES-1:0]   decision_votes,
    input logic                              decision_switch
);
    import perf_event_pkg::*;
    import sched_pkg::*;

    // the input stalls at most this long while the output drains.
    localparam int STALL_LIMIT = 2 * (EVENT_FIFO_DEPTH + DECISION_FIFO_DEPTH + 2);

    int stall_cycles;
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst || beat_ready || !decision_ready) begin
            stall_cycles <= 0;
        end else begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    // a waiting decision holds valid and data.
    hold_decision: assert property (@(posedge clk) disable iff (rst)
        decision_valid && !decision_ready |=>
            decision_valid && $stable({decision_window, decision_votes, decision_switch}))
        else begin
            fail_count++;
            $error("decision dropped or changed while stalled");
        end

    quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !decision_valid)
        else begin
            fail_count++;
            $error("decision_valid high during reset");
        end

    input_progress: assert property (@(posedge clk) disable iff (rst)
        stall_cycles <= STALL_LIMIT)
        else begin
            fail_count++;
            $error("beat_ready held low with the output draining");
        end

endmodule

bind core_sched_top core_sched_assert assert_i (.*);

/* src/core_sched_top.sv */
`timescale 1ns/1ns

module core_sched_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              beat_valid,
    output logic                              beat_ready,
    input  logic                              ooo_mult,
    input  logic                              ooo_mem,
    input  logic                              ooo_flush,
    input  logic                              ooo_rob_full,
    input  logic                              ooo_alu,
    input  logic                              ppl_mult,
    input  logic                              ppl_mem,
    input  logic                              ppl_flush,
    input  logic                              ppl_alu,

    output logic                              decision_valid,
    input  logic                              decision_ready,
    output logic [sched_pkg::WINDOW_ID_W-1:0] decision_window,
    output logic [sched_pkg::NUM_VOTES-1:0]   decision_votes,
    output logic                              decision_switch
);
    import perf_event_pkg::*;
    import sched_pkg::*;

    logic       rec_valid;
    logic       rec_ready;
    event_rec_t rec;
    logic       buf_valid;
    logic       buf_ready;
    event_rec_t buf_rec;
    logic       dec_valid;
    logic       dec_ready;
    decision_t  dec;
    decision_t  dec_out;

    perf_event_sampler sampler_i (
        .clk, .rst,
        .beat_valid, .beat_ready,
        .ooo_mult, .ooo_mem, .ooo_flush, .ooo_rob_full, .ooo_alu,
        .ppl_mult, .ppl_mem, .ppl_flush, .ppl_alu,
        .rec_valid, .rec_ready, .rec
    );

    stream_fifo #(.payload_t(event_rec_t), .DEPTH(EVENT_FIFO_DEPTH)) event_fifo_i (
        .clk, .rst,
        .in_valid (rec_valid), .in_ready (rec_ready), .in_data (rec),
        .out_valid(buf_valid), .out_ready(buf_ready), .out_data(buf_rec)
    );

    mode_scheduler sched_i (
        .clk, .rst,
        .rec_valid(buf_valid), .rec_ready(buf_ready), .rec(buf_rec),
        .dec_valid, .dec_ready, .dec
    );

    stream_fifo #(.payload_t(decision_t), .DEPTH(DECISION_FIFO_DEPTH)) dec_fifo_i (
        .clk, .rst,
        .in_valid (dec_valid), .in_ready (dec_ready), .in_data (dec),
        .out_valid(decision_valid), .out_ready(decision_ready), .out_data(dec_out)
    );

    assign decision_window = dec_out.window_id;
    assign decision_votes  = dec_out.votes;
    assign decision_switch = dec_out.switch_en;

endmodule

/* src/mode_scheduler.sv */
`timescale 1ns/1ns

module mode_scheduler (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       rec_valid,
    output logic                       rec_ready,
    input  perf_event_pkg::event_rec_t rec,

    output logic                       dec_valid,
    input  logic                       dec_ready,
    output sched_pkg::decision_t       dec
);
    import perf_event_pkg::*;
    import sched_pkg::*;

    logic [COUNT_W-1:0]                sum_ooo_mult;
    logic [COUNT_W-1:0]                sum_ooo_mem;
    logic [COUNT_W-1:0]                sum_ooo_flush;
    logic [COUNT_W-1:0]                sum_ooo_rob_full;
    logic [COUNT_W-1:0]                sum_ooo_alu;
    logic [COUNT_W-1:0]                sum_ppl_mult;
    logic [COUNT_W-1:0]                sum_ppl_mem;
    logic [COUNT_W-1:0]                sum_ppl_flush;
    logic [COUNT_W-1:0]                sum_ppl_alu;
    event_rec_t                        add;
    logic [COUNT_W-1:0]                nxt_ooo_mult;
    logic [COUNT_W-1:0]                nxt_ooo_mem;
    logic [COUNT_W-1:0]                nxt_ooo_flush;
    logic [COUNT_W-1:0]                nxt_ooo_rob_full;
    logic [COUNT_W-1:0]                nxt_ooo_alu;
    logic [COUNT_W-1:0]                nxt_ppl_mult;
    logic [COUNT_W-1:0]                nxt_ppl_mem;
    logic [COUNT_W-1:0]                nxt_ppl_flush;
    logic [COUNT_W-1:0]                nxt_ppl_alu;
    logic [$clog2(WINDOW_RECORDS)-1:0] rec_cnt;
    logic [WINDOW_ID_W-1:0]            window_id;
    logic [NUM_VOTES-1:0]              votes;
    logic                              switch_en;
    logic                              rec_fire;
    logic                              last_rec;

    // no new records while a decision waits.
    assign rec_ready = !dec_valid;
    assign rec_fire  = rec_valid && rec_ready;
    assign last_rec  = int'(rec_cnt) == WINDOW_RECORDS - 1;
    assign add       = rec;

    // window sums including the record on the input.
    always_comb begin
        nxt_ooo_mult     = sum_ooo_mult     + COUNT_W'(add.ooo_mult);
        nxt_ooo_mem      = sum_ooo_mem      + COUNT_W'(add.ooo_mem);
        nxt_ooo_flush    = sum_ooo_flush    + COUNT_W'(add.ooo_flush);
        nxt_ooo_rob_full = sum_ooo_rob_full + COUNT_W'(add.ooo_rob_full);
        nxt_ooo_alu      = sum_ooo_alu      + COUNT_W'(add.ooo_alu);
        nxt_ppl_mult     = sum_ppl_mult     + COUNT_W'(add.ppl_mult);
        nxt_ppl_mem      = sum_ppl_mem      + COUNT_W'(add.ppl_mem);
        nxt_ppl_flush    = sum_ppl_flush    + COUNT_W'(add.ppl_flush);
        nxt_ppl_alu      = sum_ppl_alu      + COUNT_W'(add.ppl_alu);
    end

    always_comb begin
        votes[VOTE_MULT]  = nxt_ooo_mult < nxt_ppl_mult;
        votes[VOTE_MEM]   = nxt_ooo_mem > nxt_ppl_mem;
        votes[VOTE_FLUSH] = nxt_ooo_flush > nxt_ppl_flush;
        votes[VOTE_ROB]   = nxt_ooo_rob_full > ROB_FULL_THRESHOLD;
        votes[VOTE_ALU]   = nxt_ooo_alu < nxt_ppl_alu;
        // any three votes, or rob pressure together with alu-heavy pipeline.
        switch_en = ($countones(votes) >= 3) || (votes[VOTE_ROB] && votes[VOTE_ALU]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_ooo_mult     <= '0;
            sum_ooo_mem      <= '0;
            sum_ooo_flush    <= '0;
            sum_ooo_rob_full <= '0;
            sum_ooo_alu      <= '0;
            sum_ppl_mult     <= '0;
            sum_ppl_mem      <= '0;
            sum_ppl_flush    <= '0;
            sum_ppl_alu      <= '0;
            rec_cnt          <= '0;
            window_id        <= '0;
            dec_valid        <= 1'b0;
        end else if (dec_valid && dec_ready) begin
            // decision taken, next window starts empty.
            sum_ooo_mult     <= '0;
            sum_ooo_mem      <= '0;
            sum_ooo_flush    <= '0;
            sum_ooo_rob_full <= '0;
            sum_ooo_alu      <= '0;
            sum_ppl_mult     <= '0;
            sum_ppl_mem      <= '0;
            sum_ppl_flush    <= '0;
            sum_ppl_alu      <= '0;
            window_id        <= window_id + 1'b1;
            dec_valid        <= 1'b0;
        end else if (rec_fire) begin
            sum_ooo_mult     <= nxt_ooo_mult;
            sum_ooo_mem      <= nxt_ooo_mem;
            sum_ooo_flush    <= nxt_ooo_flush;
            sum_ooo_rob_full <= nxt_ooo_rob_full;
            sum_ooo_alu      <= nxt_ooo_alu;
            sum_ppl_mult     <= nxt_ppl_mult;
            sum_ppl_mem      <= nxt_ppl_mem;
            sum_ppl_flush    <= nxt_ppl_flush;
            sum_ppl_alu      <= nxt_ppl_alu;
            rec_cnt          <= last_rec ? '0 : rec_cnt + 1'b1;
            dec_valid        <= last_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_fire && last_rec) begin
            dec.window_id <= window_id;
            dec.votes     <= votes;
            dec.switch_en <= switch_en;
        end
    end

endmodule

/* src/stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int OCC_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occ;
    logic             push;
    logic             pop;

    // pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (int'(ptr) == DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = int'(occ) != DEPTH;
    assign out_valid = occ != '0;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* src/perf_event_sampler.sv */
`timescale 1ns/1ns

module perf_event_sampler (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       beat_valid,
    output logic                       beat_ready,
    input  logic                       ooo_mult,
    input  logic                       ooo_mem,
    input  logic                       ooo_flush,
    input  logic                       ooo_rob_full,
    input  logic                       ooo_alu,
    input  logic                       ppl_mult,
    input  logic                       ppl_mem,
    input  logic                       ppl_flush,
    input  logic                       ppl_alu,

    output logic                       rec_valid,
    input  logic                       rec_ready,
    output perf_event_pkg::event_rec_t rec
);
    import perf_event_pkg::*;

    logic [$clog2(GROUP_BEATS)-1:0] beat_cnt;
    event_rec_t                     acc;
    event_rec_t                     acc_nxt;
    logic                           beat_fire;
    logic                           last_beat;

    // take a beat when the output register is free or drains this cycle.
    assign beat_ready = !rec_valid || rec_ready;
    assign beat_fire  = beat_valid && beat_ready;
    assign last_beat  = int'(beat_cnt) == GROUP_BEATS - 1;

    // running counts including the current beat.
    always_comb begin
        acc_nxt.ooo_mult     = acc.ooo_mult     + CNT_W'(ooo_mult);
        acc_nxt.ooo_mem      = acc.ooo_mem      + CNT_W'(ooo_mem);
        acc_nxt.ooo_flush    = acc.ooo_flush    + CNT_W'(ooo_flush);
        acc_nxt.ooo_rob_full = acc.ooo_rob_full + CNT_W'(ooo_rob_full);
        acc_nxt.ooo_alu      = acc.ooo_alu      + CNT_W'(ooo_alu);
        acc_nxt.ppl_mult     = acc.ppl_mult     + CNT_W'(ppl_mult);
        acc_nxt.ppl_mem      = acc.ppl_mem      + CNT_W'(ppl_mem);
        acc_nxt.ppl_flush    = acc.ppl_flush    + CNT_W'(ppl_flush);
        acc_nxt.ppl_alu      = acc.ppl_alu      + CNT_W'(ppl_alu);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt  <= '0;
            acc       <= '0;
            rec_valid <= 1'b0;
        end else begin
            if (rec_valid && rec_ready) begin
                rec_valid <= 1'b0;
            end
            if (beat_fire) begin
                if (last_beat) begin
                    // group complete, counts restart.
                    beat_cnt  <= '0;
                    acc       <= '0;
                    rec_valid <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                    acc      <= acc_nxt;
                end
            end
        end
    end

    // record payload, loaded with the group's final counts.
    always_ff @(posedge clk) begin
        if (beat_fire && last_beat) begin
            rec <= acc_nxt;
        end
    end

endmodule

/* src/sched_pkg.sv */
package sched_pkg;

    // window length, counted in event records.
    localparam int WINDOW_RECORDS = 16;

    // window sum width, must hold WINDOW_RECORDS * GROUP_BEATS.
    localparam int COUNT_W = 8;

    // rob-full sum above which the rob vote is cast.
    localparam logic [COUNT_W-1:0] ROB_FULL_THRESHOLD = 8'd32;

    localparam int WINDOW_ID_W = 8;
    localparam int NUM_VOTES   = 5;

    // bit positions in the vote vector.
    localparam int VOTE_MULT  = 0;
    localparam int VOTE_MEM   = 1;
    localparam int VOTE_FLUSH = 2;
    localparam int VOTE_ROB   = 3;
    localparam int VOTE_ALU   = 4;

    typedef struct packed {
        logic [WINDOW_ID_W-1:0] window_id;
        logic [NUM_VOTES-1:0]   votes;
        logic                   switch_en;
    } decision_t;

    // decisions buffered toward the output.
    localparam int DECISION_FIFO_DEPTH = 2;

endpackage

/* src/perf_event_pkg.sv */
package perf_event_pkg;

    // accepted event beats folded into one count record.
    localparam int GROUP_BEATS = 4;

    // one count must hold GROUP_BEATS.
    localparam int CNT_W = 3;

    // per-group event counts from both cores.
    typedef struct packed {
        // out-of-order core.
        logic [CNT_W-1:0] ooo_mult;
        logic [CNT_W-1:0] ooo_mem;
        logic [CNT_W-1:0] ooo_flush;
        logic [CNT_W-1:0] ooo_rob_full;
        logic [CNT_W-1:0] ooo_alu;
        // in-order pipelined core.
        logic [CNT_W-1:0] ppl_mult;
        logic [CNT_W-1:0] ppl_mem;
        logic [CNT_W-1:0] ppl_flush;
        logic [CNT_W-1:0] ppl_alu;
    } event_rec_t;

    // records buffered between sampler and scheduler.
    localparam int EVENT_FIFO_DEPTH = 4;

endpackage
